//--- cpuPkg.sv
package cpuPkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int dataWidth = 32;      // Machine word
    localparam int dataDepth = 32;      // Data memory words
    localparam int codeDepth = 64;      // Instruction memory words

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [dataWidth-1:0] word_t;               // Data or instruction word
    typedef logic [4:0] regIndex_t;                     // Register number
    typedef logic [$clog2(dataDepth)-1:0] dataIndex_t;  // Address bits 6:2
    typedef logic [$clog2(codeDepth)-1:0] codeIndex_t;  // Pc bits 7:2

    // ----------------------------------------
    // Instruction fields
    // ----------------------------------------
    typedef logic [5:0] opcode_t;   // Bits 31:26
    typedef logic [5:0] funct_t;    // Bits 5:0, R-type only

    // Opcodes, standard MIPS values
    localparam opcode_t opR    = 6'h00;   // add, sub, and, or, slt
    localparam opcode_t opJ    = 6'h02;
    localparam opcode_t opBeq  = 6'h04;
    localparam opcode_t opAddi = 6'h08;
    localparam opcode_t opLw   = 6'h23;
    localparam opcode_t opSw   = 6'h2b;

    // Function codes of the R-type group
    localparam funct_t fnAdd = 6'h20;
    localparam funct_t fnSub = 6'h22;
    localparam funct_t fnAnd = 6'h24;
    localparam funct_t fnOr  = 6'h25;
    localparam funct_t fnSlt = 6'h2a;

    // ----------------------------------------
    // Enums
    // ----------------------------------------
    // ALU operation select
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_t;

    // Controller FSM, the second state only follows an lw
    typedef enum logic {
        stExecute,      // Normal single-cycle execution
        stLoadWait      // Registered read data now valid
    } ctrlState_t;

endpackage

//--- memBus.sv
`timescale 1ns/1ns

// Core to data memory connection
interface memBus;

    import cpuPkg::*;

    word_t address;     // Byte address from the ALU
    word_t writeData;   // Store value, register rt
    logic  memWrite;    // Store strobe
    logic  memRead;     // Load strobe, data one edge later
    word_t readData;    // Registered read result

    // Core side drives the request
    modport core (
        output address, writeData, memWrite, memRead,
        input  readData
    );

    // Memory side answers it
    modport memory (
        input  address, writeData, memWrite, memRead,
        output readData
    );

endinterface

//--- alu.sv
`timescale 1ns/1ns

module alu (
    input  cpuPkg::word_t  operandA,
    input  cpuPkg::word_t  operandB,
    input  cpuPkg::aluOp_t operation,
    output cpuPkg::word_t  result,
    output logic           zero
);

    import cpuPkg::*;

    always_comb
    begin
        case (operation)
            aluAdd:  result = operandA + operandB;
            aluSub:  result = operandA - operandB;     // Also beq compare
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluSlt:
            begin
                // Signed compare, 1 or 0
                if ($signed(operandA) < $signed(operandB))
                    result = word_t'(1);
                else
                    result = '0;
            end
            default: result = '0;
        endcase
    end

    // Equal operands on sub, used by beq
    assign zero = (result == '0);

endmodule

//--- registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic              clock,
    input  logic              reset,
    input  cpuPkg::regIndex_t readIndexA,
    input  cpuPkg::regIndex_t readIndexB,
    input  cpuPkg::regIndex_t writeIndex,
    input  logic              writeEnable,
    input  cpuPkg::word_t     writeData,
    output cpuPkg::word_t     readDataA,
    output cpuPkg::word_t     readDataB
);

    import cpuPkg::*;

    word_t regs [32];   // Entry 0 never written

    // Write port takes effect at one edge
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;                  // All registers cleared
        end
        else if (writeEnable && (writeIndex != '0))
        begin
            regs[writeIndex] <= writeData;      // $zero writes dropped
        end
    end

    // Combinational read ports
    // Entry 0 reads 0 from reset and the write guard
    assign readDataA = regs[readIndexA];
    assign readDataB = regs[readIndexB];

    // $zero stays zero after any earlier write to it
    assert property (@(posedge clock) disable iff (reset)
        (readIndexA == '0) |-> (readDataA == '0))
        else $error("register 0 read back nonzero");

endmodule

//--- dataMemory.sv
`timescale 1ns/1ns

module dataMemory (
    input logic   clock,
    input logic   reset,
    memBus.memory bus
);

    import cpuPkg::*;

    word_t      mem [dataDepth];    // 32 words
    dataIndex_t wordIndex;          // Word select

    // Bits outside 6:2 ignored
    assign wordIndex = bus.address[$bits(dataIndex_t)+1:2];

    // ----------------------------------------
    // Storage and registered read
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            // Word i holds i after reset
            for (int i = 0; i < dataDepth; i++)
                mem[i] <= word_t'(i);
        end
        else if (bus.memWrite)
        begin
            mem[wordIndex] <= bus.writeData;    // Write wins over read
        end
        else if (bus.memRead)
        begin
            bus.readData <= mem[wordIndex];     // Held until next read
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Controller never issues both strobes at once
    assert property (@(posedge clock) disable iff (reset)
        !(bus.memWrite && bus.memRead))
        else $error("memWrite and memRead both high");

    // Word accesses only
    assert property (@(posedge clock) disable iff (reset)
        (bus.memWrite || bus.memRead) |-> (bus.address[1:0] == 2'b00))
        else $error("unaligned data access at %h", bus.address);

endmodule

//--- instructionMemory.sv
`timescale 1ns/1ns

module instructionMemory (
    input  logic               clock,
    input  logic               progWrite,
    input  cpuPkg::codeIndex_t progAddress,
    input  cpuPkg::word_t      progData,
    input  cpuPkg::codeIndex_t fetchIndex,
    output cpuPkg::word_t      instruction
);

    import cpuPkg::*;

    word_t code [codeDepth];    // Program store, kept over reset

    // Load port, usually used while reset is held
    always_ff @(posedge clock)
    begin
        if (progWrite)
            code[progAddress] <= progData;
    end

    // Fetch port
    assign instruction = code[fetchIndex];  // Combinational at the pc

endmodule

//--- controller.sv
`timescale 1ns/1ns

module controller (
    input  logic            clock,
    input  logic            reset,
    input  cpuPkg::opcode_t opcode,
    input  cpuPkg::funct_t  funct,
    output cpuPkg::aluOp_t  aluOperation,
    output logic            aluSrcImmediate,
    output logic            regDst,
    output logic            regWrite,
    output logic            memToReg,
    output logic            memRead,
    output logic            memWrite,
    output logic            branch,
    output logic            jump,
    output logic            pcHold
);

    import cpuPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    always_comb
    begin
        // No-op defaults
        aluOperation    = aluAdd;
        aluSrcImmediate = 1'b0;
        regDst          = 1'b0;     // rt
        regWrite        = 1'b0;
        memToReg        = 1'b0;     // ALU result
        memRead         = 1'b0;
        memWrite        = 1'b0;
        branch          = 1'b0;
        jump            = 1'b0;
        pcHold          = 1'b0;
        if (!reset)                 // Core stays quiet while held in reset
        begin
            case (opcode)
                opR:
                begin
                    regDst   = 1'b1;    // rd
                    regWrite = 1'b1;
                    case (funct)
                        fnAdd:   aluOperation = aluAdd;
                        fnSub:   aluOperation = aluSub;
                        fnAnd:   aluOperation = aluAnd;
                        fnOr:    aluOperation = aluOr;
                        fnSlt:   aluOperation = aluSlt;
                        default: regWrite = 1'b0;   // Unknown funct
                    endcase
                end
                opAddi:
                begin
                    aluSrcImmediate = 1'b1;
                    regWrite        = 1'b1;
                end
                opLw:
                begin
                    aluSrcImmediate = 1'b1;     // Address held both cycles
                    if (state == stExecute)
                    begin
                        memRead = 1'b1;         // Issue the read
                        pcHold  = 1'b1;
                    end
                    else
                    begin
                        regWrite = 1'b1;        // Read data valid now
                        memToReg = 1'b1;
                    end
                end
                opSw:
                begin
                    aluSrcImmediate = 1'b1;
                    memWrite        = 1'b1;
                end
                opBeq:
                begin
                    aluOperation = aluSub;      // Zero on equal
                    branch       = 1'b1;
                end
                opJ:     jump = 1'b1;
                default: ;                      // Unknown opcode
            endcase
        end
    end

    // ----------------------------------------
    // lw wait FSM
    // ----------------------------------------
    assign nextState = (state == stExecute && memRead) ? stLoadWait : stExecute;

    always_ff @(posedge clock)
    begin
        if (reset)
            state <= stExecute;
        else
            state <= nextState;
    end

    // Wait state follows an lw issue and nothing else
    assert property (@(posedge clock) disable iff (reset)
        (state == stLoadWait) |-> ($past(state) == stExecute && $past(opcode) == opLw))
        else $error("stLoadWait entered without lw");

endmodule

//--- cpuCore.sv
`timescale 1ns/1ns

module cpuCore (
    input  logic               clock,
    input  logic               reset,
    input  logic               progWrite,
    input  cpuPkg::codeIndex_t progAddress,
    input  cpuPkg::word_t      progData,
    output cpuPkg::word_t      pc,
    output logic               storeValid,
    output cpuPkg::word_t      storeAddress,
    output cpuPkg::word_t      storeData
);

    import cpuPkg::*;

    word_t      instruction;
    codeIndex_t fetchIndex;
    word_t      pcPlus4, branchTarget, jumpTarget, nextPc;
    word_t      immExt;         // Sign-extended offset
    word_t      readDataA, readDataB;
    word_t      aluOperandB, aluResult;
    word_t      writeBackData;
    regIndex_t  writeIndex;
    aluOp_t     aluOperation;
    logic       aluZero;
    logic       aluSrcImmediate, regDst, regWrite, memToReg;
    logic       branch, jump, pcHold;

    memBus bus ();

    // ----------------------------------------
    // Fetch and pc
    // ----------------------------------------
    assign fetchIndex = pc[$bits(codeIndex_t)+1:2];

    instructionMemory instrMem (
        .clock, .progWrite, .progAddress, .progData,
        .fetchIndex, .instruction
    );

    assign pcPlus4      = pc + 32'd4;
    assign immExt       = {{16{instruction[15]}}, instruction[15:0]};
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instruction[25:0], 2'b00};   // Region kept

    always_comb
    begin
        if (pcHold)
            nextPc = pc;                // lw first cycle
        else if (jump)
            nextPc = jumpTarget;
        else if (branch && aluZero)
            nextPc = branchTarget;      // beq taken
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            pc <= '0;
        else
            pc <= nextPc;
    end

    // ----------------------------------------
    // Decode and execute
    // ----------------------------------------
    controller ctrl (
        .clock, .reset,
        .opcode(instruction[31:26]), .funct(instruction[5:0]),
        .aluOperation, .aluSrcImmediate, .regDst, .regWrite, .memToReg,
        .memRead(bus.memRead), .memWrite(bus.memWrite),
        .branch, .jump, .pcHold
    );

    assign writeIndex    = regDst ? instruction[15:11] : instruction[20:16];   // rd or rt
    assign writeBackData = memToReg ? bus.readData : aluResult;

    registerFile regFile (
        .clock, .reset,
        .readIndexA(instruction[25:21]), .readIndexB(instruction[20:16]),
        .writeIndex, .writeEnable(regWrite), .writeData(writeBackData),
        .readDataA, .readDataB
    );

    assign aluOperandB = aluSrcImmediate ? immExt : readDataB;

    alu aluUnit (
        .operandA(readDataA), .operandB(aluOperandB), .operation(aluOperation),
        .result(aluResult), .zero(aluZero)
    );

    // ----------------------------------------
    // Data memory and store observation
    // ----------------------------------------
    assign bus.address   = aluResult;   // Base plus offset
    assign bus.writeData = readDataB;   // rt

    dataMemory dataMem (.clock, .reset, .bus(bus.memory));

    assign storeValid   = bus.memWrite;     // One cycle per sw
    assign storeAddress = bus.address;
    assign storeData    = bus.writeData;

endmodule

//--- cpuCorePrograms.svh
string testName   [6];          // One entry per program
word_t testCode   [6][16];      // Program words with unused ones left 0 as no-ops
int    storeCount [6];          // Expected stores per program
word_t expAddr    [6][4];       // Store addresses in order
word_t expData    [6][4];       // Store data in order
word_t expPc      [6][4];       // Pc of each sw in order

// Programs and expected stores
task automatic fillTable(int immA, int immB, int immNeg, int immPos);
    word_t a;
    word_t b;
    a = signExtend(immA);
    b = signExtend(immB);
    for (int t = 0; t < 6; t++)
    begin
        for (int i = 0; i < 16; i++)
            testCode[t][i] = '0;
    end

    // ----------------------------------------
    // Reset pattern, lw wait and write-back
    // ----------------------------------------
    testName[0]    = "loadSum";
    testCode[0][0] = iType(opLw, 0, 1, 12);         // Word 3
    testCode[0][1] = iType(opLw, 0, 2, 68);         // Word 17
    testCode[0][2] = rType(1, 2, 3, fnAdd);
    testCode[0][3] = iType(opSw, 0, 3, 0);
    testCode[0][4] = jType(4);                      // Park
    storeCount[0]  = 1;
    expAddr[0][0]  = 32'd0;
    expData[0][0]  = 32'd3 + 32'd17;
    expPc[0][0]    = 32'd12;                        // sw at word 3

    // Random immediates through the R-type group
    testName[1]    = "arithLogic";
    testCode[1][0] = iType(opAddi, 0, 1, immA);
    testCode[1][1] = iType(opAddi, 0, 2, immB);
    testCode[1][2] = rType(1, 2, 3, fnAdd);
    testCode[1][3] = rType(1, 2, 4, fnSub);
    testCode[1][4] = rType(1, 2, 5, fnAnd);
    testCode[1][5] = rType(1, 2, 6, fnOr);
    testCode[1][6] = iType(opSw, 0, 3, 0);
    testCode[1][7] = iType(opSw, 0, 4, 4);
    testCode[1][8] = iType(opSw, 0, 5, 8);
    testCode[1][9] = iType(opSw, 0, 6, 12);
    testCode[1][10] = jType(10);
    storeCount[1]  = 4;
    expAddr[1]     = '{32'd0, 32'd4, 32'd8, 32'd12};
    expData[1]     = '{a + b, a - b, a & b, a | b};
    expPc[1]       = '{32'd24, 32'd28, 32'd32, 32'd36};

    // Signed slt with one operand negative
    testName[2]    = "sltSigned";
    testCode[2][0] = iType(opAddi, 0, 1, immNeg);
    testCode[2][1] = iType(opAddi, 0, 2, immPos);
    testCode[2][2] = rType(1, 2, 3, fnSlt);
    testCode[2][3] = rType(2, 1, 4, fnSlt);
    testCode[2][4] = rType(0, 1, 5, fnSlt);         // 0 against a negative
    testCode[2][5] = iType(opSw, 0, 3, 16);
    testCode[2][6] = iType(opSw, 0, 4, 20);
    testCode[2][7] = iType(opSw, 0, 5, 24);
    testCode[2][8] = jType(8);
    storeCount[2]  = 3;
    expAddr[2]     = '{32'd16, 32'd20, 32'd24, 32'd0};
    expData[2]     = '{32'd1, 32'd0, 32'd0, 32'd0};  // Negative below positive and zero
    expPc[2]       = '{32'd20, 32'd24, 32'd28, 32'd0};

    // New value must replace the reset pattern in word 5
    testName[3]    = "writeReadBack";
    testCode[3][0] = iType(opAddi, 0, 1, 16'h1234);
    testCode[3][1] = iType(opSw, 0, 1, 20);
    testCode[3][2] = iType(opLw, 0, 2, 20);
    testCode[3][3] = iType(opSw, 0, 2, 24);
    testCode[3][4] = jType(4);
    storeCount[3]  = 2;
    expAddr[3]     = '{32'd20, 32'd24, 32'd0, 32'd0};
    expData[3]     = '{32'h1234, 32'h1234, 32'd0, 32'd0};
    expPc[3]       = '{32'd4, 32'd12, 32'd0, 32'd0};

    // Taken beq, beq not taken, then j
    testName[4]    = "branchJump";
    testCode[4][0] = iType(opAddi, 0, 1, 7);
    testCode[4][1] = iType(opAddi, 0, 2, 7);
    testCode[4][2] = iType(opBeq, 1, 2, 1);         // Taken over word 3
    testCode[4][3] = iType(opSw, 0, 1, 0);
    testCode[4][4] = iType(opBeq, 1, 0, 1);         // Not taken since 7 differs from 0
    testCode[4][5] = iType(opSw, 0, 1, 4);
    testCode[4][6] = jType(8);
    testCode[4][7] = iType(opSw, 0, 2, 8);          // Jumped over
    testCode[4][8] = iType(opSw, 0, 2, 12);
    testCode[4][9] = jType(9);
    storeCount[4]  = 2;
    expAddr[4]     = '{32'd4, 32'd12, 32'd0, 32'd0};
    expData[4]     = '{32'd7, 32'd7, 32'd0, 32'd0};
    expPc[4]       = '{32'd20, 32'd32, 32'd0, 32'd0};

    // $zero ignores writes
    testName[5]    = "zeroRegister";
    testCode[5][0] = iType(opAddi, 0, 0, 55);
    testCode[5][1] = iType(opSw, 0, 0, 28);
    testCode[5][2] = jType(2);
    storeCount[5]  = 1;
    expAddr[5][0]  = 32'd28;
    expData[5][0]  = 32'd0;
    expPc[5][0]    = 32'd4;
endtask

//--- cpuCoreTb.sv
`timescale 1ns/1ns

module cpuCoreTb;

    import cpuPkg::*;

    logic       clock;
    logic       reset;
    logic       progWrite;
    codeIndex_t progAddress;
    word_t      progData;
    word_t      pc;
    logic       storeValid;
    word_t      storeAddress;
    word_t      storeData;

    int passCount;
    int failCount;

    cpuCore u_dut (
        .clock, .reset, .progWrite, .progAddress, .progData,
        .pc, .storeValid, .storeAddress, .storeData
    );

    // ----------------------------------------
    // Instruction encoders and reference rules
    // ----------------------------------------
    function automatic word_t rType(int rs, int rt, int rd, funct_t fn);
        return {opR, regIndex_t'(rs), regIndex_t'(rt), regIndex_t'(rd), 5'b0, fn};
    endfunction

    function automatic word_t iType(opcode_t op, int rs, int rt, int imm);
        return {op, regIndex_t'(rs), regIndex_t'(rt), 16'(imm)};
    endfunction

    function automatic word_t jType(int target);
        return {opJ, 26'(target)};   // Word index of the target
    endfunction

    // 16-bit immediate as addi sees it
    function automatic word_t signExtend(int imm);
        logic [15:0] field;
        field = 16'(imm);
        return {{16{field[15]}}, field};
    endfunction

    `include "cpuCorePrograms.svh"

    // 100 ns clock
    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Reset held 16 cycles while one program word loads per cycle
    task automatic resetAndLoad(int t);
        for (int i = 0; i < 16; i++)
        begin
            @(posedge clock);
            reset       <= 1'b1;
            progWrite   <= 1'b1;
            progAddress <= codeIndex_t'(i);
            progData    <= testCode[t][i];
        end
        @(posedge clock);
        reset     <= 1'b0;          // Last word lands on this edge
        progWrite <= 1'b0;
    endtask

    // Next store and its pc sampled mid-cycle
    // seen stays low on timeout
    task automatic waitStore(output logic seen, output word_t addr, output word_t data,
                             output word_t pcAt);
        seen = 1'b0;
        addr = '0;
        data = '0;
        pcAt = '0;
        for (int c = 0; c < 200 && !seen; c++)
        begin
            @(negedge clock);
            if (storeValid)
            begin
                seen = 1'b1;
                addr = storeAddress;
                data = storeData;
                pcAt = pc;
            end
        end
    endtask

    // ----------------------------------------
    // One table entry
    // ----------------------------------------
    task automatic runTest(int t);
        logic  seen;
        word_t addr;
        word_t data;
        word_t pcAt;
        logic  testOk;
        testOk = 1'b1;
        resetAndLoad(t);
        for (int s = 0; s < storeCount[t]; s++)
        begin
            waitStore(seen, addr, data, pcAt);
            assert (seen)
            else
            begin
                $display("%s: store %0d never arrived within 200 cycles", testName[t], s);
                testOk = 1'b0;
            end
            if (!seen)
                break;
            assert (addr == expAddr[t][s])
            else
            begin
                $display("Error %s store %0d address: expected %h, actual %h",
                    testName[t], s, expAddr[t][s], addr);
                testOk = 1'b0;
            end
            assert (data == expData[t][s])
            else
            begin
                $display("Error %s store %0d data: expected %h, actual %h",
                    testName[t], s, expData[t][s], data);
                testOk = 1'b0;
            end
            assert (pcAt == expPc[t][s])
            else
            begin
                $display("Error %s store %0d pc: expected %h, actual %h",
                    testName[t], s, expPc[t][s], pcAt);
                testOk = 1'b0;
            end
        end
        if (testOk)
        begin
            passCount++;
            $display("test %s passed", testName[t]);
        end
        else
        begin
            failCount++;
            $display("test %s failed", testName[t]);
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial
    begin
        int immA;
        int immB;
        int immNeg;
        int immPos;
        reset       <= 1'b1;
        progWrite   <= 1'b0;
        progAddress <= '0;
        progData    <= '0;
        passCount = 0;
        failCount = 0;
        void'($urandom(32'hbb77_ec96));
        immA   = int'($urandom_range(0, 65535)) - 32768;    // Full signed range
        immB   = int'($urandom_range(0, 65535)) - 32768;
        immNeg = -1 - int'($urandom_range(0, 32767));
        immPos = int'($urandom_range(1, 32767));
        fillTable(immA, immB, immNeg, immPos);
        for (int t = 0; t < $size(testName); t++)
            runTest(t);
        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
cpuPkg.sv
memBus.sv
alu.sv
registerFile.sv
dataMemory.sv
instructionMemory.sv
controller.sv
cpuCore.sv
cpuCoreTb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sim.f --top-module cpuCoreTb -Mdir obj_dir
	./obj_dir/VcpuCoreTb | tee sim.log
	@grep -qx '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log
